// ==== hw/sdram_map_pkg.sv ====
// SDRAM bank map definitions

package sdram_map_pkg;

    // SDRAM word address width
    localparam int sdram_aw = 23;

    // Region base offsets in 16-bit words
    localparam logic [sdram_aw-1:0] vram_offset = 23'h20_0000;  // Video RAM
    localparam logic [sdram_aw-1:0] wram_offset = 23'h30_0000;  // Work RAM
    localparam logic [sdram_aw-1:0] snd_offset  = 23'h38_0000;  // Sound CPU ROM

    // Current holder of the bank port
    typedef enum logic [1:0] {
        owner_none,
        owner_load,
        owner_ram,
        owner_snd
    } owner_e;

endpackage

// ==== hw/rom_loader.sv ====
// ROM download word packer
`timescale 1ns/1ps

module rom_loader (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output logic        dwnld_busy,
    output logic        req,
    output logic [sdram_map_pkg::sdram_aw-1:0] addr,
    output logic [15:0] din,
    output logic [ 1:0] mask,     // Active low byte enables
    input  logic        ack
);

    logic [ 7:0] even_byte;
    logic [sdram_map_pkg::sdram_aw-1:0] even_addr;
    logic        even_pend;
    logic        take, wr_even, wr_odd, pair, flush_now;

    // Bytes beyond the 8M-word range are dropped
    assign take      = !req && downloading && ioctl_wr && !ioctl_addr[24];
    assign wr_even   = take && !ioctl_addr[0];
    assign wr_odd    = take && ioctl_addr[0];
    assign pair      = even_pend && (even_addr == ioctl_addr[23:1]);
    // Lone even byte goes out at the end of the download or when a new word starts
    assign flush_now = even_pend && !req && (!downloading || (wr_even && !pair));

    assign dwnld_busy = req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req       <= 1'b0;
            even_pend <= 1'b0;
        end else begin
            if (req && ack)
                req <= 1'b0;
            else if (wr_odd || flush_now)
                req <= 1'b1;
            if (wr_even)
                even_pend <= 1'b1;
            else if ((wr_odd && pair) || flush_now)
                even_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even) begin
            even_byte <= ioctl_data;
            even_addr <= ioctl_addr[23:1];
        end
        if (wr_odd) begin
            addr <= ioctl_addr[23:1];
            din  <= {ioctl_data, pair ? even_byte : 8'h00};
            mask <= pair ? 2'b00 : 2'b01;   // High byte only when unpaired
        end else if (flush_now) begin
            addr <= even_addr;
            din  <= {8'h00, even_byte};
            mask <= 2'b10;
        end
    end

endmodule

// ==== hw/ram_slot.sv ====
// Main CPU RAM slot
`timescale 1ns/1ps

module ram_slot #(
    parameter int ram_aw = 17
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ram_cs,
    input  logic              vram_cs,
    input  logic              rnw,
    input  logic [ram_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_din,
    input  logic [ 1:0]       dsn,
    output logic              ok,
    output logic [15:0]       dout,
    output logic              req,
    output logic [sdram_map_pkg::sdram_aw-1:0] addr,
    output logic              we,
    output logic [15:0]       din,
    output logic [ 1:0]       mask,
    input  logic              ack,
    input  logic              rdy,
    input  logic [15:0]       data_read
);

    localparam int aw = sdram_map_pkg::sdram_aw;

    logic          cs;
    logic          wait_rdy;
    logic          busy;
    logic          changed;
    logic          launch;
    logic [aw-1:0] full_addr;

    assign cs        = ram_cs | vram_cs;
    // Work RAM takes precedence if both selects are up
    assign full_addr = (ram_cs ? sdram_map_pkg::wram_offset : sdram_map_pkg::vram_offset)
                     + {{(aw-ram_aw){1'b0}}, cpu_addr};
    assign changed   = (full_addr != addr) || (rnw == we);
    assign busy      = req | wait_rdy;
    assign launch    = cs && !busy && (!ok || changed);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req      <= 1'b0;
            wait_rdy <= 1'b0;
            ok       <= 1'b0;
        end else if (launch) begin
            req <= 1'b1;
            ok  <= 1'b0;
        end else if (req && ack) begin
            req      <= 1'b0;
            wait_rdy <= !we;              // Reads still owe data
            ok       <= we && cs && !changed;
        end else if (wait_rdy && rdy) begin
            wait_rdy <= 1'b0;
            ok       <= cs && !changed;
        end else if (!cs || changed) begin
            ok <= 1'b0;
        end
    end

    // Request payload and read-return latch
    always_ff @(posedge clk) begin
        if (launch) begin
            addr <= full_addr;
            we   <= !rnw;
            din  <= cpu_din;
            mask <= dsn;
        end
        if (wait_rdy && rdy)
            dout <= data_read;
    end

endmodule

// ==== hw/rom_byte_slot.sv ====
// Sound CPU ROM slot with word cache
`timescale 1ns/1ps

module rom_byte_slot #(
    parameter int snd_aw = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr,
    input  logic              cs,
    input  logic [snd_aw-1:0] byte_addr,
    output logic              ok,
    output logic [ 7:0]       dout,
    output logic              req,
    output logic [sdram_map_pkg::sdram_aw-1:0] addr,
    input  logic              ack,
    input  logic              rdy,
    input  logic [15:0]       data_read
);

    localparam int aw = sdram_map_pkg::sdram_aw;
    localparam int wa = snd_aw - 1;     // Word address bits

    logic [wa-1:0] word_addr;
    logic [wa-1:0] tag;
    logic [wa-1:0] fetch_tag;
    logic [15:0]   cache_data;
    logic          cache_valid;
    logic          fill_ok;             // Cleared if clr hits an open fetch
    logic          wait_rdy;
    logic          hit;
    logic          launch;

    assign word_addr = byte_addr[snd_aw-1:1];
    assign hit       = cache_valid && (tag == word_addr);
    assign launch    = cs && !hit && !req && !wait_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req         <= 1'b0;
            wait_rdy    <= 1'b0;
            ok          <= 1'b0;
            cache_valid <= 1'b0;
            fill_ok     <= 1'b0;
        end else begin
            ok <= cs && hit && !clr;
            if (launch) begin
                req     <= 1'b1;
                fill_ok <= 1'b1;
            end else if (req && ack) begin
                req      <= 1'b0;
                wait_rdy <= 1'b1;
            end else if (wait_rdy && rdy) begin
                wait_rdy <= 1'b0;
            end
            if (clr) begin
                cache_valid <= 1'b0;
                fill_ok     <= 1'b0;
            end else if (wait_rdy && rdy) begin
                cache_valid <= fill_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr      <= sdram_map_pkg::snd_offset + {{(aw-wa){1'b0}}, word_addr};
            fetch_tag <= word_addr;
        end
        if (wait_rdy && rdy) begin
            cache_data <= data_read;
            tag        <= fetch_tag;
        end
        dout <= byte_addr[0] ? cache_data[15:8] : cache_data[7:0];  // Odd is high byte
    end

endmodule

// ==== hw/bank_arbiter.sv ====
// SDRAM bank arbiter
`timescale 1ns/1ps

module bank_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    // Write-only download writer
    input  logic        load_req,
    input  logic [sdram_map_pkg::sdram_aw-1:0] load_addr,
    input  logic [15:0] load_din,
    input  logic [ 1:0] load_mask,
    output logic        load_ack,
    // Main CPU RAM
    input  logic        ram_req,
    input  logic [sdram_map_pkg::sdram_aw-1:0] ram_addr,
    input  logic        ram_we,
    input  logic [15:0] ram_din,
    input  logic [ 1:0] ram_mask,
    output logic        ram_ack,
    output logic        ram_rdy,
    // Read-only sound ROM
    input  logic        snd_req,
    input  logic [sdram_map_pkg::sdram_aw-1:0] snd_addr,
    output logic        snd_ack,
    output logic        snd_rdy,
    // SDRAM port
    output logic [sdram_map_pkg::sdram_aw-1:0] sdram_addr,
    output logic        sdram_rd,
    output logic        sdram_wr,
    output logic [15:0] sdram_din,
    output logic [ 1:0] sdram_wrmask,
    input  logic        sdram_ack,
    input  logic        data_rdy
);

    sdram_map_pkg::owner_e owner;
    sdram_map_pkg::owner_e winner;
    logic                  acked;       // Read accepted, data pending
    logic                  active;
    logic                  cur_we;
    logic                  port_ack;
    logic                  port_rdy;

    // Fixed priority with the loader first, then RAM, then sound
    always_comb begin
        if (load_req)
            winner = sdram_map_pkg::owner_load;
        else if (ram_req)
            winner = sdram_map_pkg::owner_ram;
        else if (snd_req)
            winner = sdram_map_pkg::owner_snd;
        else
            winner = sdram_map_pkg::owner_none;
    end

    always_comb begin
        cur_we       = 1'b0;
        sdram_addr   = '0;
        sdram_din    = 16'h0000;
        sdram_wrmask = 2'b11;
        case (owner)
            sdram_map_pkg::owner_load: begin
                cur_we       = 1'b1;
                sdram_addr   = load_addr;
                sdram_din    = load_din;
                sdram_wrmask = load_mask;
            end
            sdram_map_pkg::owner_ram: begin
                cur_we       = ram_we;
                sdram_addr   = ram_addr;
                sdram_din    = ram_din;
                sdram_wrmask = ram_mask;
            end
            sdram_map_pkg::owner_snd: sdram_addr = snd_addr;
            default: ;
        endcase
    end

    assign active   = owner != sdram_map_pkg::owner_none;
    assign sdram_rd = active && !acked && !cur_we;
    assign sdram_wr = active && cur_we;
    assign port_ack = active && !acked && sdram_ack;
    assign port_rdy = acked && data_rdy;

    // Handshakes go back to the current owner only
    assign load_ack = port_ack && owner == sdram_map_pkg::owner_load;
    assign ram_ack  = port_ack && owner == sdram_map_pkg::owner_ram;
    assign snd_ack  = port_ack && owner == sdram_map_pkg::owner_snd;
    assign ram_rdy  = port_rdy && owner == sdram_map_pkg::owner_ram;
    assign snd_rdy  = port_rdy && owner == sdram_map_pkg::owner_snd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= sdram_map_pkg::owner_none;
            acked <= 1'b0;
        end else if (!active) begin
            owner <= winner;
            acked <= 1'b0;
        end else if (port_ack) begin
            if (cur_we)
                owner <= sdram_map_pkg::owner_none;  // Writes end on ack
            else
                acked <= 1'b1;
        end else if (port_rdy) begin
            owner <= sdram_map_pkg::owner_none;
            acked <= 1'b0;
        end
    end

endmodule

// ==== hw/game_mem.sv ====
// Game SDRAM access layer
`timescale 1ns/1ps

module game_mem #(
    parameter int ram_aw = 17,
    parameter int snd_aw = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    // ROM download
    input  logic              downloading,
    input  logic [24:0]       ioctl_addr,
    input  logic [ 7:0]       ioctl_data,
    input  logic              ioctl_wr,
    output logic              dwnld_busy,
    // Main CPU
    input  logic              main_ram_cs,
    input  logic              main_vram_cs,
    input  logic              main_rnw,
    input  logic [ram_aw-1:0] main_addr,
    input  logic [15:0]       main_dout,
    input  logic [ 1:0]       dsn,
    output logic              main_ram_ok,
    output logic [15:0]       main_ram_data,
    // Sound CPU
    input  logic              snd_cs,
    input  logic [snd_aw-1:0] snd_addr,
    output logic              snd_ok,
    output logic [ 7:0]       snd_data,
    // SDRAM
    output logic [sdram_map_pkg::sdram_aw-1:0] sdram_addr,
    output logic              sdram_rd,
    output logic              sdram_wr,
    output logic [15:0]       sdram_din,
    output logic [ 1:0]       sdram_wrmask,
    input  logic              sdram_ack,
    input  logic              data_rdy,
    input  logic [15:0]       data_read
);

    localparam int aw = sdram_map_pkg::sdram_aw;

    logic          load_req, load_ack;
    logic [aw-1:0] load_addr;
    logic [15:0]   load_din;
    logic [ 1:0]   load_mask;
    logic          ram_req, ram_we, ram_ack, ram_rdy;
    logic [aw-1:0] ram_addr;
    logic [15:0]   ram_din;
    logic [ 1:0]   ram_mask;
    logic          snd_req, snd_ack, snd_rdy;
    logic [aw-1:0] snd_sd_addr;
    logic          dl_last;
    logic          cache_clr;

    // Flush the sound cache as a download begins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dl_last <= 1'b0;
        else
            dl_last <= downloading;
    end
    assign cache_clr = downloading & ~dl_last;

    rom_loader u_loader (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_data  ( ioctl_data   ),
        .ioctl_wr    ( ioctl_wr     ),
        .dwnld_busy  ( dwnld_busy   ),
        .req         ( load_req     ),
        .addr        ( load_addr    ),
        .din         ( load_din     ),
        .mask        ( load_mask    ),
        .ack         ( load_ack     )
    );

    ram_slot #(.ram_aw(ram_aw)) u_ram (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .ram_cs      ( main_ram_cs  ),
        .vram_cs     ( main_vram_cs ),
        .rnw         ( main_rnw     ),
        .cpu_addr    ( main_addr    ),
        .cpu_din     ( main_dout    ),
        .dsn         ( dsn          ),
        .ok          ( main_ram_ok  ),
        .dout        ( main_ram_data),
        .req         ( ram_req      ),
        .addr        ( ram_addr     ),
        .we          ( ram_we       ),
        .din         ( ram_din      ),
        .mask        ( ram_mask     ),
        .ack         ( ram_ack      ),
        .rdy         ( ram_rdy      ),
        .data_read   ( data_read    )
    );

    rom_byte_slot #(.snd_aw(snd_aw)) u_snd (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .clr         ( cache_clr    ),
        .cs          ( snd_cs       ),
        .byte_addr   ( snd_addr     ),
        .ok          ( snd_ok       ),
        .dout        ( snd_data     ),
        .req         ( snd_req      ),
        .addr        ( snd_sd_addr  ),
        .ack         ( snd_ack      ),
        .rdy         ( snd_rdy      ),
        .data_read   ( data_read    )
    );

    bank_arbiter u_arb (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .load_req     ( load_req     ),
        .load_addr    ( load_addr    ),
        .load_din     ( load_din     ),
        .load_mask    ( load_mask    ),
        .load_ack     ( load_ack     ),
        .ram_req      ( ram_req      ),
        .ram_addr     ( ram_addr     ),
        .ram_we       ( ram_we       ),
        .ram_din      ( ram_din      ),
        .ram_mask     ( ram_mask     ),
        .ram_ack      ( ram_ack      ),
        .ram_rdy      ( ram_rdy      ),
        .snd_req      ( snd_req      ),
        .snd_addr     ( snd_sd_addr  ),
        .snd_ack      ( snd_ack      ),
        .snd_rdy      ( snd_rdy      ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rd     ( sdram_rd     ),
        .sdram_wr     ( sdram_wr     ),
        .sdram_din    ( sdram_din    ),
        .sdram_wrmask ( sdram_wrmask ),
        .sdram_ack    ( sdram_ack    ),
        .data_rdy     ( data_rdy     )
    );

endmodule

// ==== bench/mem_checker.sv ====
// Memory slot response checker
`timescale 1ns/1ps

module mem_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ram_start,
    input  logic        ram_read,     // Low for a write
    input  logic [15:0] ram_exp,
    input  int          ram_test,
    input  logic        snd_start,
    input  logic [ 7:0] snd_exp,
    input  int          snd_test,
    input  logic        main_ram_ok,
    input  logic [15:0] main_ram_data,
    input  logic        snd_ok,
    input  logic [ 7:0] snd_data,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic        ioctl_odd,    // Bit 0 of the download byte address
    input  logic        dwnld_busy,
    output logic        ram_busy,
    output logic        snd_busy,
    output int          pass_count,
    output int          fail_count
);

    localparam int wait_limit = 40;

    int          ram_id;
    int          snd_id;
    int          ram_wait;
    int          snd_wait;
    logic        ram_rd;
    logic [15:0] ram_want;
    logic [ 7:0] snd_want;
    logic        busy_due;

    task automatic score(input int id, input sdram_map_pkg::owner_e who,
                         input string what, input bit good);
        if (good)
            pass_count++;
        else
            fail_count++;
        $display("test %0d %s %s %s", id, who.name(), what, good ? "pass" : "FAIL");
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_busy   <= 1'b0;
            snd_busy   <= 1'b0;
            busy_due   <= 1'b0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            // Odd byte strobe starts a word write at the next edge
            if (busy_due && dwnld_busy !== 1'b1) begin
                fail_count++;
                $display("ERR time=%0t signal=dwnld_busy expected=1 actual=%b",
                         $time, dwnld_busy);
            end
            busy_due <= downloading && ioctl_wr && ioctl_odd && !dwnld_busy;
            // Main RAM channel
            if (ram_start) begin
                ram_busy <= 1'b1;
                ram_wait = 0;
                ram_id   = ram_test;
                ram_rd   = ram_read;
                ram_want = ram_exp;
            end else if (ram_busy && main_ram_ok) begin
                ram_busy <= 1'b0;
                if (ram_rd && main_ram_data !== ram_want)
                    $display("ERR time=%0t signal=main_ram_data expected=%h actual=%h",
                             $time, ram_want, main_ram_data);
                score(ram_id, sdram_map_pkg::owner_ram, ram_rd ? "read" : "write",
                      !ram_rd || main_ram_data === ram_want);
            end else if (ram_busy) begin
                ram_wait++;
                if (ram_wait >= wait_limit) begin
                    ram_busy <= 1'b0;
                    $display("test %0d main RAM access timed out, no ok within %0d cycles",
                             ram_id, wait_limit);
                    score(ram_id, sdram_map_pkg::owner_ram, "timeout", 1'b0);
                end
            end
            // Sound ROM channel
            if (snd_start) begin
                snd_busy <= 1'b1;
                snd_wait = 0;
                snd_id   = snd_test;
                snd_want = snd_exp;
            end else if (snd_busy && snd_ok) begin
                snd_busy <= 1'b0;
                if (snd_data !== snd_want)
                    $display("ERR time=%0t signal=snd_data expected=%h actual=%h",
                             $time, snd_want, snd_data);
                score(snd_id, sdram_map_pkg::owner_snd, "read", snd_data === snd_want);
            end else if (snd_busy) begin
                snd_wait++;
                if (snd_wait >= wait_limit) begin
                    snd_busy <= 1'b0;
                    $display("test %0d sound ROM access timed out, no ok within %0d cycles",
                             snd_id, wait_limit);
                    score(snd_id, sdram_map_pkg::owner_snd, "timeout", 1'b0);
                end
            end
        end
    end

endmodule

// ==== bench/tb_game_mem.sv ====
// Game memory testbench
`timescale 1ns/1ps

module tb_game_mem;

    localparam int    ram_aw      = 17;
    localparam int    snd_aw      = 16;
    localparam string golden_path = "bench/game_mem_golden.txt";

    logic              clk          = 1'b0;
    logic              rst_n        = 1'b0;
    logic              downloading  = 1'b0;
    logic [24:0]       ioctl_addr   = '0;
    logic [ 7:0]       ioctl_data   = 8'h00;
    logic              ioctl_wr     = 1'b0;
    logic              dwnld_busy;
    logic              main_ram_cs  = 1'b0;
    logic              main_vram_cs = 1'b0;
    logic              main_rnw     = 1'b1;
    logic [ram_aw-1:0] main_addr    = '0;
    logic [15:0]       main_dout    = 16'h0000;
    logic [ 1:0]       dsn          = 2'b11;
    logic              main_ram_ok;
    logic [15:0]       main_ram_data;
    logic              snd_cs       = 1'b0;
    logic [snd_aw-1:0] snd_addr     = '0;
    logic              snd_ok;
    logic [ 7:0]       snd_data;
    logic [22:0]       sdram_addr;
    logic              sdram_rd;
    logic              sdram_wr;
    logic [15:0]       sdram_din;
    logic [ 1:0]       sdram_wrmask;
    logic              sdram_ack    = 1'b0;
    logic              data_rdy     = 1'b0;
    logic [15:0]       data_read    = 16'h0000;

    logic        ram_start = 1'b0;
    logic        ram_read  = 1'b0;
    logic [15:0] ram_exp   = 16'h0000;
    int          ram_test  = 0;
    logic        snd_start = 1'b0;
    logic [ 7:0] snd_exp   = 8'h00;
    int          snd_test  = 0;
    logic        ram_busy;
    logic        snd_busy;
    int          pass_count;
    int          fail_count;

    // Golden operations in file order
    logic [ 7:0] op_q   [$];
    logic [ 7:0] sel_q  [$];
    logic [24:0] addr_q [$];
    logic [15:0] data_q [$];
    logic [ 1:0] mask_q [$];
    logic [15:0] exp_q  [$];
    int          checks_expected = 0;
    int          bad_ops         = 0;
    bit          golden_ok;

    // SDRAM model state
    logic [15:0] sdram_mem [logic [22:0]];
    integer      seed = 32'h42dc;
    logic [ 1:0] rsp_state = 2'd0;
    logic        rsp_read  = 1'b0;
    logic [15:0] rsp_word  = 16'h0000;
    int          rsp_delay = 0;

    int cycles      = 0;
    int cycle_limit = 0;

    game_mem #(.ram_aw(ram_aw), .snd_aw(snd_aw)) dut (
        .clk(clk), .rst_n(rst_n),
        .downloading(downloading), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .dwnld_busy(dwnld_busy),
        .main_ram_cs(main_ram_cs), .main_vram_cs(main_vram_cs), .main_rnw(main_rnw),
        .main_addr(main_addr), .main_dout(main_dout), .dsn(dsn),
        .main_ram_ok(main_ram_ok), .main_ram_data(main_ram_data),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_ok(snd_ok), .snd_data(snd_data),
        .sdram_addr(sdram_addr), .sdram_rd(sdram_rd), .sdram_wr(sdram_wr),
        .sdram_din(sdram_din), .sdram_wrmask(sdram_wrmask), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    mem_checker chk (
        .clk(clk), .rst_n(rst_n),
        .ram_start(ram_start), .ram_read(ram_read), .ram_exp(ram_exp), .ram_test(ram_test),
        .snd_start(snd_start), .snd_exp(snd_exp), .snd_test(snd_test),
        .main_ram_ok(main_ram_ok), .main_ram_data(main_ram_data),
        .snd_ok(snd_ok), .snd_data(snd_data),
        .downloading(downloading), .ioctl_wr(ioctl_wr), .ioctl_odd(ioctl_addr[0]),
        .dwnld_busy(dwnld_busy),
        .ram_busy(ram_busy), .snd_busy(snd_busy),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped at cycle %0d before the golden operations finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] read_word(input logic [22:0] a);
        return sdram_mem.exists(a) ? sdram_mem[a] : 16'h0000;
    endfunction

    function automatic void write_word(input logic [22:0] a, input logic [15:0] d,
                                       input logic [1:0] m);
        logic [15:0] w;
        w = read_word(a);
        if (!m[0])
            w[7:0] = d[7:0];     // Mask bits are active low
        if (!m[1])
            w[15:8] = d[15:8];
        sdram_mem[a] = w;
    endfunction

    // SDRAM responder acks one cycle after a request
    always @(posedge clk) begin
        case (rsp_state)
            2'd0: begin
                if (sdram_wr) begin
                    write_word(sdram_addr, sdram_din, sdram_wrmask);
                    rsp_read  = 1'b0;
                    rsp_state = 2'd1;
                    #1 sdram_ack = 1'b1;
                end else if (sdram_rd) begin
                    rsp_word  = read_word(sdram_addr);
                    rsp_read  = 1'b1;
                    rsp_state = 2'd1;
                    #1 sdram_ack = 1'b1;
                end
            end
            2'd1: begin
                rsp_delay = 1 + $unsigned($random(seed)) % 4;  // rdy 2 to 5 cycles after ack
                rsp_state = rsp_read ? 2'd2 : 2'd0;
                #1 sdram_ack = 1'b0;
            end
            2'd2: begin
                rsp_delay--;
                if (rsp_delay == 0) begin
                    rsp_state = 2'd3;
                    #1;
                    data_read = rsp_word;
                    data_rdy  = 1'b1;
                end
            end
            default: begin
                rsp_state = 2'd0;
                #1 data_rdy = 1'b0;
            end
        endcase
    end

    function automatic bit read_golden();
        int          fd;
        int          n;
        string       line;
        logic [ 7:0] op;
        logic [ 7:0] sel;
        logic [24:0] a;
        logic [15:0] d;
        logic [ 1:0] m;
        logic [15:0] e;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", golden_path);
            return 1'b0;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %c %h %h %h %h", op, sel, a, d, m, e);
                if (n == 6) begin
                    op_q.push_back(op);
                    sel_q.push_back(sel);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    mask_q.push_back(m);
                    exp_q.push_back(e);
                    if (op != "L")
                        checks_expected++;
                end
            end
        end
        $fclose(fd);
        cycle_limit = 16 + 64 * op_q.size();
        return op_q.size() > 0;
    endfunction

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        if (!downloading) begin
            downloading = 1'b1;      // Rising edge clears the sound cache
            @(posedge clk);
            #1;
        end
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        @(posedge clk);
        #1;
        while (dwnld_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_download;
        if (downloading) begin
            downloading = 1'b0;
            @(posedge clk);
            #1;
            @(posedge clk);
            #1;
            while (dwnld_busy) begin    // Trailing even byte may still go out
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic finish_access;
        @(posedge clk);
        #1;
        ram_start = 1'b0;
        snd_start = 1'b0;
        while (ram_busy || snd_busy) begin
            @(posedge clk);
            #1;
        end
        main_ram_cs  = 1'b0;
        main_vram_cs = 1'b0;
        main_rnw     = 1'b1;
        snd_cs       = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic run_op(input int i);
        logic [7:0] op;
        logic [7:0] sel;
        op  = op_q[i];
        sel = sel_q[i];
        if (op == "L") begin
            load_byte(addr_q[i], data_q[i][7:0]);
        end else begin
            end_download();
            if (op == "W" || op == "R") begin
                main_ram_cs  = (sel == "w");
                main_vram_cs = (sel == "v");
                main_rnw     = (op == "R");
                main_addr    = addr_q[i][ram_aw-1:0];
                main_dout    = data_q[i];
                dsn          = (op == "W") ? mask_q[i] : 2'b00;
                ram_read     = (op == "R");
                ram_exp      = exp_q[i];
                ram_test     = i;
                ram_start    = 1'b1;
            end else if (op == "S") begin
                snd_cs    = 1'b1;
                snd_addr  = addr_q[i][snd_aw-1:0];
                snd_exp   = exp_q[i][7:0];
                snd_test  = i;
                snd_start = 1'b1;
            end else begin
                $display("Golden line %0d holds an unknown operation %c", i, op);
                bad_ops++;
            end
            // Overlapped sound read goes out together with the next line
            if (!(op == "S" && sel == "o"))
                finish_access();
        end
    endtask

    initial begin
        golden_ok = read_golden();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (golden_ok) begin
            for (int i = 0; i < op_q.size(); i++)
                run_op(i);
            end_download();
        end
        $display("Checks passed %0d, failed %0d, expected %0d", pass_count, fail_count,
                 checks_expected);
        if (golden_ok && bad_ops == 0 && fail_count == 0 && pass_count == checks_expected)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
hw/sdram_map_pkg.sv
hw/rom_loader.sv
hw/ram_slot.sv
hw/rom_byte_slot.sv
hw/bank_arbiter.sv
hw/game_mem.sv
bench/mem_checker.sv
bench/tb_game_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the game memory testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_game_mem -o sim_game_mem
./obj_dir/sim_game_mem | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// ==== bench/game_mem_golden.txt ====
# op sel addr data mask expected, all numbers in hex
# L download byte, W/R main RAM (sel w work, v video), S sound read (sel s wait, o overlap next)
L - 600020 5a 0 0
L - 600021 c3 0 0
L - 600022 77 0 0
R w 00010 0 0 c35a
R w 00011 0 0 0077
W w 00020 1234 0 0
R w 00020 0 0 1234
W w 00020 00ab 2 0
R w 00020 0 0 12ab
W v 00020 beef 0 0
R v 00020 0 0 beef
R w 00020 0 0 12ab
L - 700008 11 0 0
L - 700009 22 0 0
L - 70000a 33 0 0
L - 70000b 44 0 0
S s 0008 0 0 11
S s 0009 0 0 22
S s 000a 0 0 33
S s 000b 0 0 44
L - 70000a 55 0 0
L - 70000b 66 0 0
S s 000b 0 0 66
S s 000a 0 0 55
S o 0008 0 0 11
R w 00010 0 0 c35a
S o 000b 0 0 66
R v 00020 0 0 beef
